//--- epl_shim_pkg.sv
/*
 * Shared definitions for the EPL transmit shim
 * Widths, port count, lane mode and TDM slot types
 * Per-mode TDM slot schedule table
 */

package epl_shim_pkg;

  // --------------------------------------------------------------------------
  // Widths and counts
  // --------------------------------------------------------------------------
  localparam int NUM_PORTS = 4;        // Source port buffers
  localparam int PORT_W    = 2;        // Port number
  localparam int NUM_FLITS = 8;        // Flits per transfer
  localparam int FLIT_W    = 72;       // 64b data + 8b ECC
  localparam int META_W    = 24;       // Per transfer metadata, passed through
  localparam int ECC_W     = 8;        // Covers metadata and data-valid
  localparam int DVALID_W  = 8;        // One bit per flit
  localparam int CFG_W     = 4;        // port_config width

  // Lane mode, decoded from port_config
  typedef enum logic [2:0] {
    LANE_ONE_PORT  = 3'd0,             // 0 0 0 0
    LANE_TWO_PORT  = 3'd1,             // 0 2 0 2
    LANE_FOUR_PORT = 3'd2,             // 0 1 2 3
    LANE_THREE_12  = 3'd3,             // 0 2 1 2
    LANE_THREE_21  = 3'd4,             // 0 2 0 3
    LANE_RSVD      = 3'd5              // Codes 5..15 of port_config
  } lane_mode_e;

  typedef enum logic [1:0] {
    TDM_SLOT0 = 2'd0,
    TDM_SLOT1 = 2'd1,
    TDM_SLOT2 = 2'd2,
    TDM_SLOT3 = 2'd3
  } tdm_slot_e;

  // --------------------------------------------------------------------------
  // Slot schedule, [lane mode][slot] -> port number
  // --------------------------------------------------------------------------
  localparam logic [PORT_W-1:0] SLOT_SCHEDULE [8][4] = '{
    '{2'd0, 2'd0, 2'd0, 2'd0},         // ONE_PORT
    '{2'd0, 2'd2, 2'd0, 2'd2},         // TWO_PORT
    '{2'd0, 2'd1, 2'd2, 2'd3},         // FOUR_PORT
    '{2'd0, 2'd2, 2'd1, 2'd2},         // THREE_12
    '{2'd0, 2'd2, 2'd0, 2'd3},         // THREE_21
    '{2'd0, 2'd0, 2'd0, 2'd0},         // Reserved
    '{2'd0, 2'd0, 2'd0, 2'd0},         // Unused encodings
    '{2'd0, 2'd0, 2'd0, 2'd0}
  };

endpackage : epl_shim_pkg

//--- epl_req_capture.sv
/*
 * epl_req_capture
 * First stage of the shim, registers the EPL request,
 * decodes port_config into the lane mode, makes the credit response
 */

`timescale 1ns/1ps

module epl_req_capture
  import epl_shim_pkg::*;
(
  input  logic              clk,
  input  logic              reset_n,
  input  logic              tx_data_enable,      // EPL ready for tx data
  input  logic [PORT_W-1:0] tx_enable_port_num,  // Port tied to tx_data_enable
  input  logic [CFG_W-1:0]  port_config,         // Lane configuration
  output logic              req_valid,           // Request delayed by one cycle
  output logic [PORT_W-1:0] req_port,
  output lane_mode_e        lane_mode,
  output logic              tx_data_valid_resp   // Credit back to EPL
);

  lane_mode_e lane_mode_nxt;

  // --------------------------------------------------------------------------
  // port_config decode
  // --------------------------------------------------------------------------
  always_comb begin
    case (port_config)
      4'd0:    lane_mode_nxt = LANE_ONE_PORT;
      4'd1:    lane_mode_nxt = LANE_TWO_PORT;
      4'd2:    lane_mode_nxt = LANE_FOUR_PORT;
      4'd3:    lane_mode_nxt = LANE_THREE_12;
      4'd4:    lane_mode_nxt = LANE_THREE_21;
      default: lane_mode_nxt = LANE_RSVD;       // 5..15 all reserved
    endcase
  end

  // --------------------------------------------------------------------------
  // Request and mode registers
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      req_valid          <= 1'b0;
      req_port           <= '0;
      lane_mode          <= LANE_ONE_PORT;    // Slot 0 is port 0 in any mode
      tx_data_valid_resp <= 1'b0;
    end else begin
      req_valid          <= tx_data_enable;
      req_port           <= tx_enable_port_num;
      lane_mode          <= lane_mode_nxt;    // New config one cycle later
      tx_data_valid_resp <= req_valid;        // Second delay for the credit
    end
  end

endmodule : epl_req_capture

//--- tdm_slot_sequencer.sv
/*
 * tdm_slot_sequencer
 * Free-running four-slot TDM counter and the
 * scheduled port lookup for the current slot and lane mode
 */

`timescale 1ns/1ps

module tdm_slot_sequencer
  import epl_shim_pkg::*;
(
  input  logic              clk,
  input  logic              reset_n,
  input  lane_mode_e        lane_mode,    // Registered lane mode
  output logic [PORT_W-1:0] sched_port    // Port owning this cycle
);

  tdm_slot_e slot;

  // --------------------------------------------------------------------------
  // Slot counter
  // --------------------------------------------------------------------------
  // Zero in the first cycle out of reset, then steps every cycle.
  // Wraps 3 -> 0 by overflow
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      slot <= TDM_SLOT0;
    end else begin
      slot <= tdm_slot_e'(slot + 2'd1);
    end
  end

  // --------------------------------------------------------------------------
  // Schedule lookup
  // --------------------------------------------------------------------------
  // Purely combinational, zero cycles of latency.
  // Reserved modes read the all-zero rows of the table
  always_comb begin
    sched_port = SLOT_SCHEDULE[lane_mode][slot];
  end

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------
  // Slot never stalls or skips once reset is gone
  a_slot_step : assert property (
    @(posedge clk) disable iff (!reset_n)
    $past(reset_n) |-> (slot == tdm_slot_e'($past(slot) + 2'd1))
  );

endmodule : tdm_slot_sequencer

//--- epl_port_mux.sv
/*
 * epl_port_mux
 * Buffer read generation, port mismatch flag and the
 * output register stage that drives the EPL transmit bus
 */

`timescale 1ns/1ps

module epl_port_mux
  import epl_shim_pkg::*;
(
  input  logic                                 clk,
  input  logic                                 reset_n,
  // Registered request and schedule
  input  logic                                 req_valid,
  input  logic [PORT_W-1:0]                    req_port,
  input  logic [PORT_W-1:0]                    sched_port,
  // Per-port buffer side
  input  logic                                 tc_rdy          [NUM_PORTS],
  input  logic [NUM_FLITS-1:0][FLIT_W-1:0]     port_flits      [NUM_PORTS],
  input  logic [META_W-1:0]                    port_metadata   [NUM_PORTS],
  input  logic [ECC_W-1:0]                     port_ecc        [NUM_PORTS],
  input  logic [DVALID_W-1:0]                  port_data_valid [NUM_PORTS],
  // One buffer read bit per port
  output logic [NUM_PORTS-1:0]                 buf_ren,
  output logic                                 port_num_err,   // To CSR status
  // EPL transmit channel
  output logic [PORT_W-1:0]                    tx_port_num,
  output logic [NUM_FLITS-1:0][FLIT_W-1:0]     tx_flits,       // SOP in lowest flit
  output logic [META_W-1:0]                    tx_metadata,
  output logic [ECC_W-1:0]                     tx_ecc,
  output logic [DVALID_W-1:0]                  tx_data_valid
);

  logic rd_hit;      // Read of the scheduled port this cycle
  logic port_match;  // Requested port owns the slot

  // --------------------------------------------------------------------------
  // Buffer read
  // --------------------------------------------------------------------------
  // Request valid, port owns the slot and buffer ready all together
  assign port_match = (req_port == sched_port);
  assign rd_hit     = req_valid && port_match && tc_rdy[sched_port];

  always_comb begin
    buf_ren             = '0;
    buf_ren[sched_port] = rd_hit;      // Only the slot owner can be read
  end

  // --------------------------------------------------------------------------
  // EPL output register
  // --------------------------------------------------------------------------
  // Port number follows the schedule even without a read so the EPL
  // always sees where the slot went. Payload is taken from the slot owner
  // every cycle and the valid mask says whether it means anything
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      tx_port_num   <= '0;
      tx_flits      <= '0;
      tx_metadata   <= '0;
      tx_ecc        <= '0;
      tx_data_valid <= '0;
      port_num_err  <= 1'b0;
    end else begin
      tx_port_num   <= sched_port;
      tx_flits      <= port_flits[sched_port];
      tx_metadata   <= port_metadata[sched_port];   // Not decoded here
      tx_ecc        <= port_ecc[sched_port];        // Not checked here
      tx_data_valid <= rd_hit ? port_data_valid[sched_port] : '0;
      // Mismatch only counts while a request is active
      port_num_err  <= req_valid && !port_match;
    end
  end

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------
  // Never more than one buffer read per cycle
  a_ren_onehot : assert property (
    @(posedge clk) disable iff (!reset_n)
    $onehot0(buf_ren)
  );

  // A read needs its port's ready, and the data lands next cycle
  // tagged with that same port
  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_rd_chk
    a_ren_rdy : assert property (
      @(posedge clk) disable iff (!reset_n)
      buf_ren[p] |-> tc_rdy[p] ##1 (tx_port_num == PORT_W'(p))
    );
  end

endmodule : epl_port_mux

//--- epl_tx_shim_top.sv
/*
 * epl_tx_shim_top
 * Egress shim between four transmit port buffers and one EPL
 * transmit channel. Request capture, TDM sequencer, port mux
 */

`timescale 1ns/1ps

module epl_tx_shim_top
  import epl_shim_pkg::*;
(
  input  logic                                 clk,
  input  logic                                 reset_n,
  // EPL request
  input  logic                                 tx_data_enable,
  input  logic [PORT_W-1:0]                    tx_enable_port_num,
  output logic                                 tx_data_valid_resp,  // Credit
  // Configuration and status
  input  logic [CFG_W-1:0]                     port_config,
  output logic                                 port_num_err,
  // Port buffers
  input  logic                                 tc_rdy          [NUM_PORTS],
  input  logic [NUM_FLITS-1:0][FLIT_W-1:0]     port_flits      [NUM_PORTS],
  input  logic [META_W-1:0]                    port_metadata   [NUM_PORTS],
  input  logic [ECC_W-1:0]                     port_ecc        [NUM_PORTS],
  input  logic [DVALID_W-1:0]                  port_data_valid [NUM_PORTS],
  output logic                                 buf_ren_port0,
  output logic                                 buf_ren_port1,
  output logic                                 buf_ren_port2,
  output logic                                 buf_ren_port3,
  // EPL transmit channel
  output logic [PORT_W-1:0]                    tx_port_num,
  output logic [NUM_FLITS-1:0][FLIT_W-1:0]     tx_flits,
  output logic [META_W-1:0]                    tx_metadata,
  output logic [ECC_W-1:0]                     tx_ecc,
  output logic [DVALID_W-1:0]                  tx_data_valid
);

  // --------------------------------------------------------------------------
  // Stage to stage wires
  // --------------------------------------------------------------------------
  logic                 req_valid;     // Request, one cycle late
  logic [PORT_W-1:0]    req_port;
  lane_mode_e           lane_mode;     // Registered mode
  logic [PORT_W-1:0]    sched_port;    // Slot owner this cycle
  logic [NUM_PORTS-1:0] buf_ren;

  // Stage 1, request and config capture
  epl_req_capture i_epl_req_capture (
    .clk                (clk),
    .reset_n            (reset_n),
    .tx_data_enable     (tx_data_enable),
    .tx_enable_port_num (tx_enable_port_num),
    .port_config        (port_config),
    .req_valid          (req_valid),
    .req_port           (req_port),
    .lane_mode          (lane_mode),
    .tx_data_valid_resp (tx_data_valid_resp)
  );

  // Stage 2, slot counter and schedule lookup
  tdm_slot_sequencer i_tdm_slot_sequencer (
    .clk        (clk),
    .reset_n    (reset_n),
    .lane_mode  (lane_mode),
    .sched_port (sched_port)
  );

  // Stage 3, reads and EPL output register
  epl_port_mux i_epl_port_mux (
    .clk             (clk),
    .reset_n         (reset_n),
    .req_valid       (req_valid),
    .req_port        (req_port),
    .sched_port      (sched_port),
    .tc_rdy          (tc_rdy),
    .port_flits      (port_flits),
    .port_metadata   (port_metadata),
    .port_ecc        (port_ecc),
    .port_data_valid (port_data_valid),
    .buf_ren         (buf_ren),
    .port_num_err    (port_num_err),
    .tx_port_num     (tx_port_num),
    .tx_flits        (tx_flits),
    .tx_metadata     (tx_metadata),
    .tx_ecc          (tx_ecc),
    .tx_data_valid   (tx_data_valid)
  );

  // --------------------------------------------------------------------------
  // Per-port read strobes to the buffers
  // --------------------------------------------------------------------------
  assign buf_ren_port0 = buf_ren[0];
  assign buf_ren_port1 = buf_ren[1];
  assign buf_ren_port2 = buf_ren[2];
  assign buf_ren_port3 = buf_ren[3];

endmodule : epl_tx_shim_top

//--- tb_epl_tx_shim_tests.svh
/*
 * Directed tests for the EPL transmit shim
 * Reference slot schedule, per-cycle checker, reset and traffic drivers
 */

`ifndef TB_EPL_TX_SHIM_TESTS_SVH
`define TB_EPL_TX_SHIM_TESTS_SVH

localparam int KIND_IDLE     = 0;   // No requests
localparam int KIND_MATCH    = 1;   // Request the slot owner every cycle
localparam int KIND_BP       = 2;   // Slot owner not ready
localparam int KIND_CREDIT   = 3;   // Random enable
localparam int KIND_MISMATCH = 4;   // Every third request names a wrong port

// Per-cycle history, index 0 is the first cycle out of reset
logic                 en_h   [MAX_N];
logic [PORT_W-1:0]    port_h [MAX_N];
logic [NUM_PORTS-1:0] rdy_h  [MAX_N];
logic                 rd_h   [MAX_N];   // Read expected in that cycle
logic                 mm_h   [MAX_N];   // Mismatch seen in that cycle

// Reference TDM schedule, port for a port_config code and slot
function automatic logic [PORT_W-1:0] slot_port(input int cfg, input int slot);
  logic [PORT_W-1:0] row [4];
  case (cfg)
    1:       row = '{2'd0, 2'd2, 2'd0, 2'd2};    // TWO_PORT
    2:       row = '{2'd0, 2'd1, 2'd2, 2'd3};    // FOUR_PORT
    3:       row = '{2'd0, 2'd2, 2'd1, 2'd2};    // THREE_12
    4:       row = '{2'd0, 2'd2, 2'd0, 2'd3};    // THREE_21
    default: row = '{2'd0, 2'd0, 2'd0, 2'd0};    // ONE_PORT, reserved
  endcase
  return row[slot % 4];
endfunction

task automatic check_value(input string test, input string what,
                           input logic [575:0] exp, input logic [575:0] act);
  check_count++;
  if (act !== exp) begin
    err_count++;
    $display("[FAIL] %s %s expected %0h actual %0h", test, what, exp, act);
  end
endtask

task automatic check_ren(input string test, input int c, input logic [NUM_PORTS-1:0] exp);
  check_count++;
  if (ren_v !== exp) begin
    err_count++;
    if ((exp & ~ren_v) != '0)
      $display("%s: buffer read missing in cycle %0d, strobes %b", test, c, ren_v);
    else
      $display("%s: unexpected buffer read in cycle %0d, strobes %b", test, c, ren_v);
  end
endtask

// Everything the DUT drives must be zero
task automatic check_idle(input string test);
  check_ren(test, -1, '0);
  check_value(test, "tx_data_valid_resp", '0, tx_data_valid_resp);
  check_value(test, "port_num_err", '0, port_num_err);
  check_value(test, "tx_port_num", '0, tx_port_num);
  check_value(test, "tx_flits", '0, tx_flits);
  check_value(test, "tx_metadata", '0, tx_metadata);
  check_value(test, "tx_ecc", '0, tx_ecc);
  check_value(test, "tx_data_valid", '0, tx_data_valid);
endtask

task automatic set_port_data();
  logic [95:0] wide;
  for (int p = 0; p < NUM_PORTS; p++) begin
    for (int f = 0; f < NUM_FLITS; f++) begin
      wide = {$random(seed), $random(seed), $random(seed)};
      port_flits[p][f] = wide[FLIT_W-1:0];
    end
    port_metadata[p]   = META_W'($random(seed));
    port_ecc[p]        = ECC_W'($random(seed));
    port_data_valid[p] = DVALID_W'($random(seed)) | 8'h01;   // Never empty
  end
endtask

// Holds reset for RST_CYCLES edges, returns at the first cycle out of reset
task automatic apply_reset(input string test, input int cfg, input logic busy);
  port_config        = CFG_W'(cfg);
  reset_n            = 1'b0;
  tx_data_enable     = busy;            // Must be ignored in reset
  tx_enable_port_num = '0;
  for (int p = 0; p < NUM_PORTS; p++) tc_rdy[p] = 1'b1;
  set_port_data();
  for (int i = 0; i < RST_CYCLES; i++) begin
    @(negedge clk);
    if (i > 0) check_idle(test);        // First reset edge not seen yet at i = 0
    @(posedge clk);
    #1;
  end
  reset_n = 1'b1;
endtask

// Expected DUT state in cycle c, from the requests driven so far
task automatic check_cycle(input string test, input int cfg, input int c);
  logic [PORT_W-1:0]    sp;
  logic [PORT_W-1:0]    sp_prev;
  logic [NUM_PORTS-1:0] exp_ren;
  sp      = slot_port(cfg, c % 4);
  rd_h[c] = 1'b0;
  mm_h[c] = 1'b0;
  if (c > 0) begin
    rd_h[c] = en_h[c-1] && (port_h[c-1] == sp) && rdy_h[c][sp];
    mm_h[c] = en_h[c-1] && (port_h[c-1] != sp);
  end
  exp_ren = '0;
  if (rd_h[c]) exp_ren[sp] = 1'b1;
  check_ren(test, c, exp_ren);
  if (c == 0) begin
    check_idle(test);                   // Still the reset values
  end else begin
    sp_prev = slot_port(cfg, (c - 1) % 4);
    check_value(test, "tx_port_num", sp_prev, tx_port_num);
    check_value(test, "tx_flits", port_flits[sp_prev], tx_flits);
    check_value(test, "tx_metadata", port_metadata[sp_prev], tx_metadata);
    check_value(test, "tx_ecc", port_ecc[sp_prev], tx_ecc);
    check_value(test, "tx_data_valid", rd_h[c-1] ? port_data_valid[sp_prev] : '0,
                tx_data_valid);
    check_value(test, "port_num_err", mm_h[c-1], port_num_err);
    check_value(test, "tx_data_valid_resp", (c >= 2) ? en_h[c-2] : 1'b0,
                tx_data_valid_resp);
  end
endtask

task automatic run_traffic(input string test, input int cfg, input int kind, input int n,
                           output int reads, output int errs);
  logic [NUM_PORTS-1:0] rdy_v;
  logic [PORT_W-1:0]    sp_next;
  int                   r;
  reads = 0;
  errs  = 0;
  for (int c = 0; c < n; c++) begin
    sp_next   = slot_port(cfg, (c + 1) % 4);   // Owner when the request lands
    r         = $random(seed);
    rdy_v     = '1;
    en_h[c]   = 1'b1;
    port_h[c] = sp_next;
    case (kind)
      KIND_IDLE:     en_h[c] = 1'b0;
      KIND_BP:       rdy_v[slot_port(cfg, c % 4)] = 1'b0;
      KIND_CREDIT:   en_h[c] = r[0];
      KIND_MISMATCH: if (c % 3 == 1) port_h[c] = sp_next + 2'd1;
      default:       ;
    endcase
    rdy_h[c]           = rdy_v;
    tx_data_enable     = en_h[c];
    tx_enable_port_num = port_h[c];
    for (int p = 0; p < NUM_PORTS; p++) tc_rdy[p] = rdy_v[p];
    @(negedge clk);                     // Mid-cycle, outputs settled
    check_cycle(test, cfg, c);
    if (ren_v != '0) reads++;
    if (port_num_err === 1'b1) errs++;
    @(posedge clk);
    #1;
  end
endtask

// ------------------------------------------------------------------------
// Directed tests
// ------------------------------------------------------------------------
task automatic test_schedule();
  int cfgs [6] = '{0, 1, 2, 3, 4, 9};  // All lane modes plus one reserved code
  int reads;
  int errs;
  for (int m = 0; m < 6; m++) begin
    apply_reset($sformatf("schedule_cfg%0d", cfgs[m]), cfgs[m], 1'b0);
    run_traffic($sformatf("schedule_cfg%0d", cfgs[m]), cfgs[m], KIND_IDLE, SCHED_N,
                reads, errs);
  end
endtask

task automatic test_transfer();
  int reads;
  int errs;
  apply_reset("transfer", 2, 1'b0);
  run_traffic("transfer", 2, KIND_MATCH, XFER_N, reads, errs);
  if (reads != XFER_N - 1) begin
    err_count++;
    $display("transfer: %0d buffer reads seen, %0d expected", reads, XFER_N - 1);
  end
endtask

task automatic test_backpressure();
  int reads;
  int errs;
  apply_reset("backpressure", 2, 1'b0);
  run_traffic("backpressure", 2, KIND_BP, BP_N, reads, errs);
  if (reads != 0) begin
    err_count++;
    $display("backpressure: %0d buffer reads while the slot owner was not ready", reads);
  end
endtask

task automatic test_credit();
  int reads;
  int errs;
  apply_reset("credit", 2, 1'b0);
  run_traffic("credit", 2, KIND_CREDIT, CREDIT_N, reads, errs);
endtask

task automatic test_mismatch();
  int reads;
  int errs;
  int exp_errs;
  exp_errs = 0;
  for (int c = 0; c <= MISM_N - 3; c++) begin
    if (c % 3 == 1) exp_errs++;         // Flag shows two cycles after the request
  end
  apply_reset("mismatch", 2, 1'b0);
  run_traffic("mismatch", 2, KIND_MISMATCH, MISM_N, reads, errs);
  if (errs != exp_errs) begin
    err_count++;
    $display("mismatch: port_num_err pulsed %0d times, %0d wrong requests made",
             errs, exp_errs);
  end
endtask

// Reset in the middle of traffic, with the EPL still requesting
task automatic test_reset();
  int reads;
  int errs;
  apply_reset("reset", 2, 1'b0);
  run_traffic("reset", 2, KIND_MATCH, RSTT_N, reads, errs);
  apply_reset("reset", 2, 1'b1);
  run_traffic("reset", 2, KIND_MATCH, RSTT_N, reads, errs);
endtask

`endif

//--- tb_epl_tx_shim.sv
/*
 * Testbench top for the EPL transmit shim
 * Clock, reset, DUT, port signals, watchdog and the closing summary
 * Directed tests come from the included test file
 */

`timescale 1ns/1ps

module tb_epl_tx_shim
  import epl_shim_pkg::*;
();

  // ------------------------------------------------------------------------
  // Run lengths in clock cycles
  // ------------------------------------------------------------------------
  localparam int CLK_PERIOD = 8;
  localparam int RST_CYCLES = 16;
  localparam int SCHED_N    = 9;      // Eight tx_port_num samples plus slot 0
  localparam int XFER_N     = 40;
  localparam int BP_N       = 24;
  localparam int CREDIT_N   = 64;
  localparam int MISM_N     = 24;
  localparam int RSTT_N     = 16;
  localparam int MAX_N      = 128;    // History depth
  localparam int TEST_CYCLES = 6 * (RST_CYCLES + SCHED_N) + (RST_CYCLES + XFER_N)
                             + (RST_CYCLES + BP_N) + (RST_CYCLES + CREDIT_N)
                             + (RST_CYCLES + MISM_N) + 2 * (RST_CYCLES + RSTT_N) + 4;

  logic                             clk = 1'b0;
  logic                             reset_n;
  logic                             tx_data_enable;
  logic [PORT_W-1:0]                tx_enable_port_num;
  logic                             tx_data_valid_resp;
  logic [CFG_W-1:0]                 port_config;
  logic                             port_num_err;
  logic                             tc_rdy          [NUM_PORTS];
  logic [NUM_FLITS-1:0][FLIT_W-1:0] port_flits      [NUM_PORTS];
  logic [META_W-1:0]                port_metadata   [NUM_PORTS];
  logic [ECC_W-1:0]                 port_ecc        [NUM_PORTS];
  logic [DVALID_W-1:0]              port_data_valid [NUM_PORTS];
  logic                             buf_ren_port0;
  logic                             buf_ren_port1;
  logic                             buf_ren_port2;
  logic                             buf_ren_port3;
  logic [NUM_PORTS-1:0]             ren_v;         // Read strobes as one vector
  logic [PORT_W-1:0]                tx_port_num;
  logic [NUM_FLITS-1:0][FLIT_W-1:0] tx_flits;
  logic [META_W-1:0]                tx_metadata;
  logic [ECC_W-1:0]                 tx_ecc;
  logic [DVALID_W-1:0]              tx_data_valid;

  integer seed        = 32'hfa13_b036;
  int     err_count   = 0;
  int     check_count = 0;

  assign ren_v = {buf_ren_port3, buf_ren_port2, buf_ren_port1, buf_ren_port0};

  always #(CLK_PERIOD / 2) clk = ~clk;

  epl_tx_shim_top i_epl_tx_shim_top (
    .clk                (clk),
    .reset_n            (reset_n),
    .tx_data_enable     (tx_data_enable),
    .tx_enable_port_num (tx_enable_port_num),
    .tx_data_valid_resp (tx_data_valid_resp),
    .port_config        (port_config),
    .port_num_err       (port_num_err),
    .tc_rdy             (tc_rdy),
    .port_flits         (port_flits),
    .port_metadata      (port_metadata),
    .port_ecc           (port_ecc),
    .port_data_valid    (port_data_valid),
    .buf_ren_port0      (buf_ren_port0),
    .buf_ren_port1      (buf_ren_port1),
    .buf_ren_port2      (buf_ren_port2),
    .buf_ren_port3      (buf_ren_port3),
    .tx_port_num        (tx_port_num),
    .tx_flits           (tx_flits),
    .tx_metadata        (tx_metadata),
    .tx_ecc             (tx_ecc),
    .tx_data_valid      (tx_data_valid)
  );

  `include "tb_epl_tx_shim_tests.svh"

  // ------------------------------------------------------------------------
  // Test sequence and summary
  // ------------------------------------------------------------------------
  initial begin
    reset_n            = 1'b0;
    tx_data_enable     = 1'b0;
    tx_enable_port_num = '0;
    port_config        = '0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      tc_rdy[p]          = 1'b0;
      port_flits[p]      = '0;
      port_metadata[p]   = '0;
      port_ecc[p]        = '0;
      port_data_valid[p] = '0;
    end
    @(posedge clk);
    #1;                                 // Stimulus lives 1 ns past the edge
    test_schedule();
    test_transfer();
    test_backpressure();
    test_credit();
    test_mismatch();
    test_reset();
    $display("Checks run: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // Watchdog at twice the nominal run time
  initial begin
    #(TEST_CYCLES * CLK_PERIOD * 2);
    $display("Watchdog expired before the tests finished, errors so far: %0d", err_count);
    $display("TB FAILED");
    $finish;
  end

endmodule : tb_epl_tx_shim

//--- epl_tx_shim.f
+incdir+.
epl_shim_pkg.sv
epl_req_capture.sv
tdm_slot_sequencer.sv
epl_port_mux.sv
epl_tx_shim_top.sv
tb_epl_tx_shim.sv
